// ==== verilog/version.svh ====
`ifndef VERSION_SVH
`define VERSION_SVH

// identification words, read back at addresses 1 to 4
localparam logic [31:0] PRODUCT_ID = 32'h0000_1588;
localparam logic [31:0] VERSION    = 32'h0001_0002;

// build stamp words
localparam logic [31:0] BUILD_DATE = 32'h0BD0_0001;
localparam logic [31:0] BUILD_TIME = 32'h0B70_0001;

`endif

// ==== verilog/ptp_pkg.sv ====
`default_nettype none

package ptp_pkg;

    // ------------------------------
    // host bus
    // ------------------------------
    localparam int ADDR_WIDTH = 10;
    localparam int DATA_WIDTH = 32;

    // identification block
    localparam logic [ADDR_WIDTH-1:0] ADDR_PRODUCT_ID      = 10'd1;
    localparam logic [ADDR_WIDTH-1:0] ADDR_VERSION         = 10'd2;
    localparam logic [ADDR_WIDTH-1:0] ADDR_BUILD_DATE      = 10'd3;
    localparam logic [ADDR_WIDTH-1:0] ADDR_BUILD_TIME      = 10'd4;
    localparam logic [ADDR_WIDTH-1:0] ADDR_SCRATCH         = 10'd8;

    // rtc block
    localparam logic [ADDR_WIDTH-1:0] ADDR_RTC_MODE        = 10'd16;
    localparam logic [ADDR_WIDTH-1:0] ADDR_SECOND          = 10'd17;
    localparam logic [ADDR_WIDTH-1:0] ADDR_NANOSECOND      = 10'd18;
    localparam logic [ADDR_WIDTH-1:0] ADDR_TIMESET         = 10'd19;
    localparam logic [ADDR_WIDTH-1:0] ADDR_TIMEGET         = 10'd20;
    localparam logic [ADDR_WIDTH-1:0] ADDR_STAT_SECOND     = 10'd21;
    localparam logic [ADDR_WIDTH-1:0] ADDR_STAT_NANOSECOND = 10'd22;

    // trigger block
    localparam logic [ADDR_WIDTH-1:0] ADDR_TRIG_ENABLE     = 10'd32;
    localparam logic [ADDR_WIDTH-1:0] ADDR_TRIG_SOURCE     = 10'd33;
    localparam logic [ADDR_WIDTH-1:0] ADDR_TRIG_SECOND     = 10'd34;
    localparam logic [ADDR_WIDTH-1:0] ADDR_TRIG_NANOSECOND = 10'd35;

    localparam logic [DATA_WIDTH-1:0] UNMAPPED_DATA = 32'hDEADBEEF;

    // ------------------------------
    // timekeeping
    // ------------------------------
    // 100 MHz clock, 10 ns per tick
    localparam logic [31:0] NS_PER_CLK = 32'd10;
    localparam logic [31:0] NS_PER_SEC = 32'd1_000_000_000;

    // trigger sources, code 2 is reserved and never fires
    localparam logic [1:0] TRIG_SRC_MCU = 2'd0;
    localparam logic [1:0] TRIG_SRC_EXT = 2'd1;
    localparam logic [1:0] TRIG_SRC_RTC = 2'd3;

endpackage

`default_nettype wire

// ==== verilog/ptp_regs.sv ====
`default_nettype none

module ptp_regs (
    input  var logic                            clk,
    input  var logic                            rst,
    // host write channel
    input  var logic [ptp_pkg::ADDR_WIDTH-1:0]  up_wr_addr,
    input  var logic                            up_wr_req,
    input  var logic [ptp_pkg::DATA_WIDTH-1:0]  up_wr_din,
    output var logic                            up_wr_ack,
    // host read channel
    input  var logic [ptp_pkg::ADDR_WIDTH-1:0]  up_rd_addr,
    input  var logic                            up_rd_req,
    output var logic [ptp_pkg::DATA_WIDTH-1:0]  up_rd_dout,
    output var logic                            up_rd_ack,
    // general purpose
    output var logic [31:0]                     ctrl_scratch,
    // rtc control, mode 0 = normal, 1 = pps
    output var logic                            ctrl_rtc_mode,
    output var logic [31:0]                     ctrl_second,
    output var logic [31:0]                     ctrl_nanosecond,
    output var logic                            ctrl_timeset,
    output var logic                            ctrl_timeget,
    // rtc snapshot
    input  var logic [31:0]                     stat_second,
    input  var logic [31:0]                     stat_nanosecond,
    // trigger control
    output var logic                            ctrl_trigger_enable,
    output var logic [1:0]                      ctrl_trigger_source,
    output var logic [31:0]                     ctrl_trigger_second,
    output var logic [31:0]                     ctrl_trigger_nanosecond
);

    // address map
    //   1..4    identification (read only)
    //   8       scratch
    //   16..18  rtc mode, second, nanosecond
    //   19, 20  timeset / timeget pulses, read as zero
    //   21, 22  snapshot second, nanosecond (read only)
    //   32..35  trigger enable, source, second, nanosecond

`include "version.svh"

    // ------------------------------
    // write side
    // ------------------------------

    // held registers
    always_ff @(posedge clk) begin
        if (rst) begin
            ctrl_scratch            <= '0;
            ctrl_rtc_mode           <= 1'b0;
            ctrl_second             <= '0;
            ctrl_nanosecond         <= '0;
            ctrl_trigger_enable     <= 1'b0;
            ctrl_trigger_source     <= '0;
            ctrl_trigger_second     <= '0;
            ctrl_trigger_nanosecond <= '0;
        end else if (up_wr_req) begin
            case (up_wr_addr)
                ptp_pkg::ADDR_SCRATCH: begin
                    ctrl_scratch <= up_wr_din;
                end
                ptp_pkg::ADDR_RTC_MODE: begin
                    ctrl_rtc_mode <= up_wr_din[0];
                end
                ptp_pkg::ADDR_SECOND: begin
                    ctrl_second <= up_wr_din;
                end
                ptp_pkg::ADDR_NANOSECOND: begin
                    ctrl_nanosecond <= up_wr_din;
                end
                ptp_pkg::ADDR_TRIG_ENABLE: begin
                    ctrl_trigger_enable <= up_wr_din[0];
                end
                ptp_pkg::ADDR_TRIG_SOURCE: begin
                    ctrl_trigger_source <= up_wr_din[1:0];
                end
                ptp_pkg::ADDR_TRIG_SECOND: begin
                    ctrl_trigger_second <= up_wr_din;
                end
                ptp_pkg::ADDR_TRIG_NANOSECOND: begin
                    ctrl_trigger_nanosecond <= up_wr_din;
                end
                default: begin
                end
            endcase
        end
    end

    // self-clearing strobes, high for one cycle after the write
    always_ff @(posedge clk) begin
        if (rst) begin
            ctrl_timeset <= 1'b0;
            ctrl_timeget <= 1'b0;
        end else begin
            ctrl_timeset <= up_wr_req && (up_wr_addr == ptp_pkg::ADDR_TIMESET)
                            && up_wr_din[0];
            ctrl_timeget <= up_wr_req && (up_wr_addr == ptp_pkg::ADDR_TIMEGET)
                            && up_wr_din[0];
        end
    end

    // every write is taken, ack one cycle later
    always_ff @(posedge clk) begin
        if (rst) begin
            up_wr_ack <= 1'b0;
        end else begin
            up_wr_ack <= up_wr_req;
        end
    end

    // ------------------------------
    // read side
    // ------------------------------

    // data holds until the next read request
    always_ff @(posedge clk) begin
        if (rst) begin
            up_rd_dout <= '0;
        end else if (up_rd_req) begin
            case (up_rd_addr)
                ptp_pkg::ADDR_PRODUCT_ID:      up_rd_dout <= PRODUCT_ID;
                ptp_pkg::ADDR_VERSION:         up_rd_dout <= VERSION;
                ptp_pkg::ADDR_BUILD_DATE:      up_rd_dout <= BUILD_DATE;
                ptp_pkg::ADDR_BUILD_TIME:      up_rd_dout <= BUILD_TIME;
                ptp_pkg::ADDR_SCRATCH:         up_rd_dout <= ctrl_scratch;
                ptp_pkg::ADDR_RTC_MODE:        up_rd_dout <= {31'b0, ctrl_rtc_mode};
                ptp_pkg::ADDR_SECOND:          up_rd_dout <= ctrl_second;
                ptp_pkg::ADDR_NANOSECOND:      up_rd_dout <= ctrl_nanosecond;
                ptp_pkg::ADDR_TIMESET:         up_rd_dout <= '0;
                ptp_pkg::ADDR_TIMEGET:         up_rd_dout <= '0;
                ptp_pkg::ADDR_STAT_SECOND:     up_rd_dout <= stat_second;
                ptp_pkg::ADDR_STAT_NANOSECOND: up_rd_dout <= stat_nanosecond;
                ptp_pkg::ADDR_TRIG_ENABLE:     up_rd_dout <= {31'b0, ctrl_trigger_enable};
                ptp_pkg::ADDR_TRIG_SOURCE:     up_rd_dout <= {30'b0, ctrl_trigger_source};
                ptp_pkg::ADDR_TRIG_SECOND:     up_rd_dout <= ctrl_trigger_second;
                ptp_pkg::ADDR_TRIG_NANOSECOND: up_rd_dout <= ctrl_trigger_nanosecond;
                default:                       up_rd_dout <= ptp_pkg::UNMAPPED_DATA;
            endcase
        end
    end

    // read response after one clock
    always_ff @(posedge clk) begin
        if (rst) begin
            up_rd_ack <= 1'b0;
        end else begin
            up_rd_ack <= up_rd_req;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/rtc_counter.sv ====
`default_nettype none

module rtc_counter (
    input  var logic        clk,
    input  var logic        rst,
    // asynchronous pulse per second
    input  var logic        pps_in,
    // control from the register block
    input  var logic        ctrl_rtc_mode,
    input  var logic [31:0] ctrl_second,
    input  var logic [31:0] ctrl_nanosecond,
    input  var logic        ctrl_timeset,
    input  var logic        ctrl_timeget,
    // live time
    output var logic [31:0] rtc_second,
    output var logic [31:0] rtc_nanosecond,
    // snapshot
    output var logic [31:0] stat_second,
    output var logic [31:0] stat_nanosecond,
    output var logic        pps_rise
);

    logic        pps_meta;
    logic        pps_sync;
    logic        pps_sync_d;
    logic [32:0] ns_sum;
    logic        ns_wrap;

    // ------------------------------
    // pps synchronizer
    // ------------------------------

    // two flops, then edge detect, pulse 3 cycles after the input edge
    always_ff @(posedge clk) begin
        if (rst) begin
            pps_meta   <= 1'b0;
            pps_sync   <= 1'b0;
            pps_sync_d <= 1'b0;
            pps_rise   <= 1'b0;
        end else begin
            pps_meta   <= pps_in;
            pps_sync   <= pps_meta;
            pps_sync_d <= pps_sync;
            pps_rise   <= pps_sync && !pps_sync_d;
        end
    end

    // ------------------------------
    // time counter
    // ------------------------------

    // one extra bit so a loaded value near the top cannot overflow
    assign ns_sum  = {1'b0, rtc_nanosecond} + {1'b0, ptp_pkg::NS_PER_CLK};
    assign ns_wrap = (ns_sum >= {1'b0, ptp_pkg::NS_PER_SEC});

    always_ff @(posedge clk) begin
        if (rst) begin
            rtc_second     <= '0;
            rtc_nanosecond <= '0;
        end else if (ctrl_timeset) begin
            rtc_second     <= ctrl_second;
            rtc_nanosecond <= ctrl_nanosecond;
        end else if (ctrl_rtc_mode) begin
            // pps mode, the pulse marks the second boundary
            if (pps_rise) begin
                rtc_second     <= rtc_second + 32'd1;
                rtc_nanosecond <= '0;
            end else if (ns_wrap) begin
                rtc_nanosecond <= ptp_pkg::NS_PER_SEC - ptp_pkg::NS_PER_CLK;
            end else begin
                rtc_nanosecond <= ns_sum[31:0];
            end
        end else if (ns_wrap) begin
            rtc_second     <= rtc_second + 32'd1;
            rtc_nanosecond <= ns_sum[31:0] - ptp_pkg::NS_PER_SEC;
        end else begin
            rtc_nanosecond <= ns_sum[31:0];
        end
    end

    // snapshot for the host
    always_ff @(posedge clk) begin
        if (rst) begin
            stat_second     <= '0;
            stat_nanosecond <= '0;
        end else if (ctrl_timeget) begin
            stat_second     <= rtc_second;
            stat_nanosecond <= rtc_nanosecond;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/trigger_gen.sv ====
`default_nettype none

module trigger_gen (
    input  var logic        clk,
    input  var logic        rst,
    // control from the register block
    input  var logic        ctrl_trigger_enable,
    input  var logic [1:0]  ctrl_trigger_source,
    input  var logic [31:0] ctrl_trigger_second,
    input  var logic [31:0] ctrl_trigger_nanosecond,
    // live time and pps from the rtc
    input  var logic [31:0] rtc_second,
    input  var logic [31:0] rtc_nanosecond,
    input  var logic        pps_rise,
    // one-cycle output pulse
    output var logic        trigger_out
);

    logic enable_d;
    logic enable_rise;
    logic enable_fall;
    logic armed;
    logic time_reached;
    logic event_hit;
    logic fire;

    // ------------------------------
    // arming
    // ------------------------------

    assign enable_rise = ctrl_trigger_enable && !enable_d;
    assign enable_fall = !ctrl_trigger_enable && enable_d;

    // seconds decide first, nanoseconds only on equal seconds
    assign time_reached = (rtc_second > ctrl_trigger_second) ||
                          ((rtc_second == ctrl_trigger_second) &&
                           (rtc_nanosecond >= ctrl_trigger_nanosecond));

    always_comb begin
        case (ctrl_trigger_source)
            ptp_pkg::TRIG_SRC_MCU: event_hit = 1'b1;
            ptp_pkg::TRIG_SRC_EXT: event_hit = pps_rise;
            ptp_pkg::TRIG_SRC_RTC: event_hit = time_reached;
            default:               event_hit = 1'b0;
        endcase
    end

    assign fire = armed && event_hit;

    // one shot per arming
    always_ff @(posedge clk) begin
        if (rst) begin
            enable_d <= 1'b0;
            armed    <= 1'b0;
        end else begin
            enable_d <= ctrl_trigger_enable;
            if (enable_fall) begin
                armed <= 1'b0;
            end else if (enable_rise) begin
                armed <= 1'b1;
            end else if (fire) begin
                armed <= 1'b0;
            end
        end
    end

    // ------------------------------
    // output
    // ------------------------------

    always_ff @(posedge clk) begin
        if (rst) begin
            trigger_out <= 1'b0;
        end else begin
            trigger_out <= fire;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/ptp_timer_top.sv ====
`default_nettype none

module ptp_timer_top (
    input  var logic                            clk,
    input  var logic                            rst,
    // host register bus
    input  var logic [ptp_pkg::ADDR_WIDTH-1:0]  up_wr_addr,
    input  var logic                            up_wr_req,
    input  var logic [ptp_pkg::DATA_WIDTH-1:0]  up_wr_din,
    output var logic                            up_wr_ack,
    input  var logic [ptp_pkg::ADDR_WIDTH-1:0]  up_rd_addr,
    input  var logic                            up_rd_req,
    output var logic [ptp_pkg::DATA_WIDTH-1:0]  up_rd_dout,
    output var logic                            up_rd_ack,
    // timing i/o
    input  var logic                            pps_in,
    output var logic                            trigger_out
);

    // register block to rtc
    logic        ctrl_rtc_mode;
    logic [31:0] ctrl_second;
    logic [31:0] ctrl_nanosecond;
    logic        ctrl_timeset;
    logic        ctrl_timeget;
    logic [31:0] stat_second;
    logic [31:0] stat_nanosecond;

    // register block to trigger
    logic        ctrl_trigger_enable;
    logic [1:0]  ctrl_trigger_source;
    logic [31:0] ctrl_trigger_second;
    logic [31:0] ctrl_trigger_nanosecond;

    // rtc to trigger
    logic [31:0] rtc_second;
    logic [31:0] rtc_nanosecond;
    logic        pps_rise;

    // scratch stays inside the register block
    ptp_regs u_regs (
        .clk                     (clk),
        .rst                     (rst),
        .up_wr_addr              (up_wr_addr),
        .up_wr_req               (up_wr_req),
        .up_wr_din               (up_wr_din),
        .up_wr_ack               (up_wr_ack),
        .up_rd_addr              (up_rd_addr),
        .up_rd_req               (up_rd_req),
        .up_rd_dout              (up_rd_dout),
        .up_rd_ack               (up_rd_ack),
        .ctrl_scratch            (),
        .ctrl_rtc_mode           (ctrl_rtc_mode),
        .ctrl_second             (ctrl_second),
        .ctrl_nanosecond         (ctrl_nanosecond),
        .ctrl_timeset            (ctrl_timeset),
        .ctrl_timeget            (ctrl_timeget),
        .stat_second             (stat_second),
        .stat_nanosecond         (stat_nanosecond),
        .ctrl_trigger_enable     (ctrl_trigger_enable),
        .ctrl_trigger_source     (ctrl_trigger_source),
        .ctrl_trigger_second     (ctrl_trigger_second),
        .ctrl_trigger_nanosecond (ctrl_trigger_nanosecond)
    );

    rtc_counter u_rtc (
        .clk             (clk),
        .rst             (rst),
        .pps_in          (pps_in),
        .ctrl_rtc_mode   (ctrl_rtc_mode),
        .ctrl_second     (ctrl_second),
        .ctrl_nanosecond (ctrl_nanosecond),
        .ctrl_timeset    (ctrl_timeset),
        .ctrl_timeget    (ctrl_timeget),
        .rtc_second      (rtc_second),
        .rtc_nanosecond  (rtc_nanosecond),
        .stat_second     (stat_second),
        .stat_nanosecond (stat_nanosecond),
        .pps_rise        (pps_rise)
    );

    trigger_gen u_trigger (
        .clk                     (clk),
        .rst                     (rst),
        .ctrl_trigger_enable     (ctrl_trigger_enable),
        .ctrl_trigger_source     (ctrl_trigger_source),
        .ctrl_trigger_second     (ctrl_trigger_second),
        .ctrl_trigger_nanosecond (ctrl_trigger_nanosecond),
        .rtc_second              (rtc_second),
        .rtc_nanosecond          (rtc_nanosecond),
        .pps_rise                (pps_rise),
        .trigger_out             (trigger_out)
    );

endmodule

`default_nettype wire

// ==== test/tb_ptp_timer.sv ====
`default_nettype none

module tb_ptp_timer;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int AW = ptp_pkg::ADDR_WIDTH;
    // a few thousand cycles for the whole run
    localparam int TIMEOUT_CYCLES = 20000;

    localparam logic [31:0] EXP_PRODUCT_ID = 32'h0000_1588;
    localparam logic [31:0] EXP_VERSION    = 32'h0001_0002;
    localparam logic [31:0] EXP_BUILD_DATE = 32'h0BD0_0001;
    localparam logic [31:0] EXP_BUILD_TIME = 32'h0B70_0001;

    logic          clk;
    logic          rst;
    logic [AW-1:0] up_wr_addr;
    logic          up_wr_req;
    logic [31:0]   up_wr_din;
    logic          up_wr_ack;
    logic [AW-1:0] up_rd_addr;
    logic          up_rd_req;
    logic [31:0]   up_rd_dout;
    logic          up_rd_ack;
    logic          pps_in;
    logic          trigger_out;

    int seed = 32'h2dd0;
    int checks = 0;
    int errors = 0;
    int run_cycles = 0;
    int trig_count = 0;

    // model registers, time and snapshot
    logic [31:0] m_scratch = '0;
    logic [31:0] m_second = '0;
    logic [31:0] m_nanosecond = '0;
    logic [31:0] m_trig_sec = '0;
    logic [31:0] m_trig_ns = '0;
    logic        m_mode = 1'b0;
    logic        m_trig_en = 1'b0;
    logic [1:0]  m_trig_src = '0;
    logic [31:0] m_sec = '0;
    logic [31:0] m_ns = '0;
    logic [31:0] m_stat_sec = '0;
    logic [31:0] m_stat_ns = '0;
    logic        ts_pend = 1'b0;
    logic        tg_pend = 1'b0;
    logic        pps_prev = 1'b0;
    logic [2:0]  pps_due = '0;
    longint      ns_next;
    longint      last_tot = 0;
    longint      fire_tot = 0;

    ptp_timer_top dut_i (
        .clk         (clk),
        .rst         (rst),
        .up_wr_addr  (up_wr_addr),
        .up_wr_req   (up_wr_req),
        .up_wr_din   (up_wr_din),
        .up_wr_ack   (up_wr_ack),
        .up_rd_addr  (up_rd_addr),
        .up_rd_req   (up_rd_req),
        .up_rd_dout  (up_rd_dout),
        .up_rd_ack   (up_rd_ack),
        .pps_in      (pps_in),
        .trigger_out (trigger_out)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] rand32();
        return $random(seed);
    endfunction

    function automatic int rand_range(input int lo, input int hi);
        return lo + int'(rand32() % 32'(hi - lo + 1));
    endfunction

    function automatic longint total_ns(input logic [31:0] sec, input logic [31:0] ns);
        return longint'(sec) * longint'(ptp_pkg::NS_PER_SEC) + longint'(ns);
    endfunction

    // ------------------------------
    // reference model
    // ------------------------------
    always @(posedge clk) begin
        if (!rst) begin
            if (tg_pend) begin
                m_stat_sec = m_sec;
                m_stat_ns  = m_ns;
            end
            last_tot = total_ns(m_sec, m_ns);
            ns_next  = longint'(m_ns) + longint'(ptp_pkg::NS_PER_CLK);
            if (ts_pend) begin
                m_sec = m_second;
                m_ns  = m_nanosecond;
            end else if (m_mode && pps_due[2]) begin
                m_sec = m_sec + 32'd1;
                m_ns  = '0;
            end else if (m_mode) begin
                // no wrap in pps mode until the pulse
                m_ns = (ns_next >= longint'(ptp_pkg::NS_PER_SEC)) ?
                       ptp_pkg::NS_PER_SEC - ptp_pkg::NS_PER_CLK : 32'(ns_next);
            end else if (ns_next >= longint'(ptp_pkg::NS_PER_SEC)) begin
                m_sec = m_sec + 32'd1;
                m_ns  = 32'(ns_next - longint'(ptp_pkg::NS_PER_SEC));
            end else begin
                m_ns = 32'(ns_next);
            end
            // pps_rise acts 3 cycles after the input edge is first seen
            pps_due  = {pps_due[1:0], pps_in && !pps_prev};
            pps_prev = pps_in;
            ts_pend  = up_wr_req && (up_wr_addr == ptp_pkg::ADDR_TIMESET) && up_wr_din[0];
            tg_pend  = up_wr_req && (up_wr_addr == ptp_pkg::ADDR_TIMEGET) && up_wr_din[0];
            if (up_wr_req) begin
                case (up_wr_addr)
                    ptp_pkg::ADDR_SCRATCH:         m_scratch    = up_wr_din;
                    ptp_pkg::ADDR_RTC_MODE:        m_mode       = up_wr_din[0];
                    ptp_pkg::ADDR_SECOND:          m_second     = up_wr_din;
                    ptp_pkg::ADDR_NANOSECOND:      m_nanosecond = up_wr_din;
                    ptp_pkg::ADDR_TRIG_ENABLE:     m_trig_en    = up_wr_din[0];
                    ptp_pkg::ADDR_TRIG_SOURCE:     m_trig_src   = up_wr_din[1:0];
                    ptp_pkg::ADDR_TRIG_SECOND:     m_trig_sec   = up_wr_din;
                    ptp_pkg::ADDR_TRIG_NANOSECOND: m_trig_ns    = up_wr_din;
                    default: ;
                endcase
            end
        end
    end

    // a pulse seen here fired on the time of the cycle before
    always @(negedge clk) begin
        if (trigger_out) begin
            trig_count++;
            fire_tot = last_tot;
        end
    end

    function automatic logic [31:0] expected_read(input logic [AW-1:0] addr);
        case (addr)
            ptp_pkg::ADDR_PRODUCT_ID:      return EXP_PRODUCT_ID;
            ptp_pkg::ADDR_VERSION:         return EXP_VERSION;
            ptp_pkg::ADDR_BUILD_DATE:      return EXP_BUILD_DATE;
            ptp_pkg::ADDR_BUILD_TIME:      return EXP_BUILD_TIME;
            ptp_pkg::ADDR_SCRATCH:         return m_scratch;
            ptp_pkg::ADDR_RTC_MODE:        return {31'b0, m_mode};
            ptp_pkg::ADDR_SECOND:          return m_second;
            ptp_pkg::ADDR_NANOSECOND:      return m_nanosecond;
            ptp_pkg::ADDR_TIMESET:         return '0;
            ptp_pkg::ADDR_TIMEGET:         return '0;
            ptp_pkg::ADDR_STAT_SECOND:     return m_stat_sec;
            ptp_pkg::ADDR_STAT_NANOSECOND: return m_stat_ns;
            ptp_pkg::ADDR_TRIG_ENABLE:     return {31'b0, m_trig_en};
            ptp_pkg::ADDR_TRIG_SOURCE:     return {30'b0, m_trig_src};
            ptp_pkg::ADDR_TRIG_SECOND:     return m_trig_sec;
            ptp_pkg::ADDR_TRIG_NANOSECOND: return m_trig_ns;
            default:                       return ptp_pkg::UNMAPPED_DATA;
        endcase
    endfunction

    function automatic logic [AW-1:0] rw_address(input int idx);
        case (idx)
            0:       return ptp_pkg::ADDR_SCRATCH;
            1:       return ptp_pkg::ADDR_RTC_MODE;
            2:       return ptp_pkg::ADDR_SECOND;
            3:       return ptp_pkg::ADDR_NANOSECOND;
            4:       return ptp_pkg::ADDR_TRIG_ENABLE;
            5:       return ptp_pkg::ADDR_TRIG_SOURCE;
            6:       return ptp_pkg::ADDR_TRIG_SECOND;
            default: return ptp_pkg::ADDR_TRIG_NANOSECOND;
        endcase
    endfunction

    // ------------------------------
    // bus and check tasks
    // ------------------------------
    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, expected);
        end
    endtask

    // one request and its ack one cycle later
    task automatic access_reg(input logic is_read, input logic [AW-1:0] addr,
                              input logic [31:0] data, output logic [31:0] got);
        int waited;
        up_wr_addr = addr;
        up_rd_addr = addr;
        up_wr_din  = data;
        up_wr_req  = !is_read;
        up_rd_req  = is_read;
        waited = 0;
        do begin
            wait_cycles(1);
            up_wr_req = 1'b0;
            up_rd_req = 1'b0;
            waited++;
        end while (!(is_read ? up_rd_ack : up_wr_ack) && waited < 8);
        got = up_rd_dout;
        checks++;
        if (waited != 1) begin
            errors++;
            $display("[ERROR] %0t ns: ack for address %0d not seen one cycle after request",
                     $time, addr);
        end
    endtask

    task automatic write_reg(input logic [AW-1:0] addr, input logic [31:0] data);
        logic [31:0] unused;
        access_reg(1'b0, addr, data, unused);
    endtask

    task automatic check_read(input logic [AW-1:0] addr, output logic [31:0] got);
        access_reg(1'b1, addr, '0, got);
        check_value($sformatf("read of address %0d", addr), got, expected_read(addr));
    endtask

    task automatic load_time(input logic [31:0] sec, input logic [31:0] ns);
        write_reg(ptp_pkg::ADDR_SECOND, sec);
        write_reg(ptp_pkg::ADDR_NANOSECOND, ns);
        write_reg(ptp_pkg::ADDR_TIMESET, 32'd1);
    endtask

    task automatic take_snapshot(output logic [31:0] sec, output logic [31:0] ns);
        write_reg(ptp_pkg::ADDR_TIMEGET, 32'd1);
        // snapshot readable two cycles after the write
        wait_cycles(1);
        check_read(ptp_pkg::ADDR_STAT_SECOND, sec);
        check_read(ptp_pkg::ADDR_STAT_NANOSECOND, ns);
    endtask

    task automatic pulse_pps();
        pps_in = 1'b1;
        wait_cycles(3);
        pps_in = 1'b0;
    endtask

    task automatic expect_one_trigger(input int base);
        int waited;
        waited = 0;
        while (trig_count == base && waited < 200) begin
            wait_cycles(1);
            waited++;
        end
        wait_cycles(20);
        checks++;
        if (trig_count - base != 1) begin
            errors++;
            $display("[ERROR] %0t ns: expected one trigger pulse, saw %0d", $time,
                     trig_count - base);
        end
    endtask

    task automatic arm_trigger(input logic [1:0] source, output int base);
        write_reg(ptp_pkg::ADDR_TRIG_ENABLE, 32'd0);
        write_reg(ptp_pkg::ADDR_TRIG_SOURCE, {30'b0, source});
        base = trig_count;
        write_reg(ptp_pkg::ADDR_TRIG_ENABLE, 32'd1);
    endtask

    // ------------------------------
    // watchdog
    // ------------------------------
    initial begin
        while (run_cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            run_cycles++;
        end
        $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        logic [31:0] got;
        logic [31:0] got_sec;
        logic [31:0] got_ns;
        logic [31:0] sec0;
        longint      target;
        int          base;
        rst        = 1'b1;
        up_wr_addr = '0;
        up_wr_req  = 1'b0;
        up_wr_din  = '0;
        up_rd_addr = '0;
        up_rd_req  = 1'b0;
        pps_in     = 1'b0;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;

        // random register traffic with reads back
        for (int i = 0; i < 1000; i++) begin
            write_reg(rw_address(rand_range(0, 7)), rand32());
            if (rand_range(0, 1) == 1) begin
                check_read(rw_address(rand_range(0, 7)), got);
            end
        end
        write_reg(ptp_pkg::ADDR_TRIG_ENABLE, 32'd0);
        write_reg(ptp_pkg::ADDR_RTC_MODE, 32'd0);

        // identification, strobes and unmapped space
        for (int a = 0; a <= 4; a++) begin
            check_read(AW'(a), got);
        end
        check_read(ptp_pkg::ADDR_TIMESET, got);
        check_read(ptp_pkg::ADDR_TIMEGET, got);
        for (int i = 0; i < 20; i++) begin
            check_read(AW'(rand_range(36, 1023)), got);
        end

        // load, run, snapshot
        for (int i = 0; i < 6; i++) begin
            load_time(rand32(), 32'(rand_range(0, 999_999_999)));
            wait_cycles(rand_range(50, 300));
            take_snapshot(got_sec, got_ns);
        end

        // nanosecond wrap into the next second
        for (int k = 1; k <= 5; k++) begin
            sec0 = rand32();
            load_time(sec0, ptp_pkg::NS_PER_SEC - ptp_pkg::NS_PER_CLK * 32'(k));
            wait_cycles(10);
            take_snapshot(got_sec, got_ns);
            check_value("second after wrap", got_sec, sec0 + 32'd1);
        end

        // trigger on rtc time, on the host and on pps
        load_time(32'd100, 32'd0);
        wait_cycles(5);
        target = total_ns(m_sec, m_ns) + longint'(rand_range(300, 600));
        write_reg(ptp_pkg::ADDR_TRIG_SECOND, 32'(target / longint'(ptp_pkg::NS_PER_SEC)));
        write_reg(ptp_pkg::ADDR_TRIG_NANOSECOND, 32'(target % longint'(ptp_pkg::NS_PER_SEC)));
        arm_trigger(ptp_pkg::TRIG_SRC_RTC, base);
        expect_one_trigger(base);
        checks++;
        if (fire_tot < target || fire_tot >= target + longint'(ptp_pkg::NS_PER_CLK)) begin
            errors++;
            $display("[ERROR] %0t ns: rtc trigger fired at model time %0d, target %0d",
                     $time, fire_tot, target);
        end
        arm_trigger(ptp_pkg::TRIG_SRC_MCU, base);
        expect_one_trigger(base);
        arm_trigger(ptp_pkg::TRIG_SRC_EXT, base);
        wait_cycles(5);
        checks++;
        if (trig_count != base) begin
            errors++;
            $display("[ERROR] %0t ns: ext trigger fired before the pps edge", $time);
        end
        pulse_pps();
        expect_one_trigger(base);
        write_reg(ptp_pkg::ADDR_TRIG_ENABLE, 32'd0);

        // pps mode with and without a pulse
        write_reg(ptp_pkg::ADDR_RTC_MODE, 32'd1);
        sec0 = rand32();
        load_time(sec0, 32'd0);
        wait_cycles(20);
        pulse_pps();
        wait_cycles(20);
        take_snapshot(got_sec, got_ns);
        check_value("second after pps", got_sec, sec0 + 32'd1);
        checks++;
        if (got_ns > ptp_pkg::NS_PER_CLK * 32'd40) begin
            errors++;
            $display("[ERROR] %0t ns: nanoseconds %0d did not restart on pps", $time, got_ns);
        end
        load_time(sec0, ptp_pkg::NS_PER_SEC - 32'd50);
        wait_cycles(30);
        take_snapshot(got_sec, got_ns);
        check_value("second without pps", got_sec, sec0);
        check_value("held nanosecond", got_ns, ptp_pkg::NS_PER_SEC - ptp_pkg::NS_PER_CLK);
        write_reg(ptp_pkg::ADDR_RTC_MODE, 32'd0);

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+verilog
verilog/ptp_pkg.sv
verilog/ptp_regs.sv
verilog/rtc_counter.sv
verilog/trigger_gen.sv
verilog/ptp_timer_top.sv
test/tb_ptp_timer.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the ptp timer testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --timescale 1ns/1ps \
    --top-module tb_ptp_timer -Mdir obj_dir -o sim_ptp_timer -f compile.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim_ptp_timer 2>&1)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "Result: PASSED"; then
    exit 0
fi
echo "simulation did not pass"
exit 1
